/* common/wisc_pkg.sv */
`default_nettype none

package wisc_pkg;

  localparam int unsigned WORD_W = 16;

  typedef logic [WORD_W-1:0] word_t;

  // Exception handler entry point
  localparam word_t EXC_VECTOR = 16'h0002;

  typedef enum logic [2:0] {
    ALU_ROL = 3'b000,
    ALU_SLL = 3'b001,
    ALU_ROR = 3'b010,
    ALU_SRL = 3'b011,
    ALU_ADD = 3'b100,
    ALU_OR  = 3'b101,
    ALU_XOR = 3'b110,
    ALU_AND = 3'b111
  } alu_op_e;

  typedef enum logic [1:0] {
    FWD_RF    = 2'b00,
    FWD_WB    = 2'b01,
    FWD_PRIOR = 2'b10
  } fwd_sel_e;

  typedef enum logic [1:0] {
    B_OP2  = 2'b00,
    B_IMM5 = 2'b01,
    B_ZERO = 2'b10
  } b_sel_e;

  typedef enum logic [1:0] {
    RES_ALU  = 2'b00,
    RES_SLBI = 2'b01,
    RES_BTR  = 2'b10,
    RES_COND = 2'b11
  } res_sel_e;

  typedef struct packed {
    logic [4:0] opcode;
    logic [2:0] rs;
    logic [7:0] imm;
  } br_fmt_t;

  typedef struct packed {
    logic [4:0] opcode;
    logic [2:0] rs;
    logic [2:0] rt;
    logic [2:0] rd;
    logic [1:0] func;
  } r_fmt_t;

  typedef union packed {
    br_fmt_t br_fmt;
    r_fmt_t  r_fmt;
  } instr_u;

  typedef struct packed {
    word_t    instr;
    word_t    pc;
    word_t    pc_plus_two;
    word_t    data1;
    word_t    data2;
    word_t    imm5;
    word_t    imm8;
    word_t    imm11;
    fwd_sel_e fwd_a;
    fwd_sel_e fwd_b;
    b_sel_e   b_sel;
    alu_op_e  alu_op;
    logic     cin;
    logic     inv_a;
    logic     inv_b;
    logic     sign_op;
    res_sel_e res_sel;
    logic     is_set;
    logic     jump;
    logic     branch;
    logic     exception;
    logic     rti;
  } issue_t;

  typedef struct packed {
    word_t data;
    logic  valid;
  } result_t;

  typedef struct packed {
    word_t next_pc;
    logic  flush;
  } redirect_t;

endpackage

`default_nettype wire

/* execute/alu.sv */
`timescale 1ns/1ns
`default_nettype none

module alu import wisc_pkg::*; #(
  parameter int DATA_W = 16
) (
  input  word_t   a,
  input  word_t   b,
  input  alu_op_e op,
  input  logic    cin,
  input  logic    inv_a,
  input  logic    inv_b,
  input  logic    sign_op,
  output word_t   out,
  output logic    ofl,
  output logic    cout,
  output logic    neg,
  output logic    zero
);

  localparam int SH_W = $clog2(DATA_W);

  logic [DATA_W-1:0]   a_in;
  logic [DATA_W-1:0]   b_in;
  logic [SH_W-1:0]     sh;
  logic [2*DATA_W-1:0] rol_full;
  logic [2*DATA_W-1:0] ror_full;
  logic [DATA_W-1:0]   sum;
  logic                carry;
  logic                sgn_ofl;
  logic                is_add;

  assign a_in = inv_a ? ~a : a;
  assign b_in = inv_b ? ~b : b;
  assign sh   = b_in[SH_W-1:0];

  // Rotates work on a doubled copy of the operand
  assign rol_full = {a_in, a_in} << sh;
  assign ror_full = {a_in, a_in} >> sh;

  assign {carry, sum} = a_in + b_in + cin;

  // Same input signs but a different sum sign
  assign sgn_ofl = (a_in[DATA_W-1] == b_in[DATA_W-1]) &&
                   (sum[DATA_W-1] != a_in[DATA_W-1]);

  always_comb begin
    case (op)
      ALU_ROL: out = rol_full[2*DATA_W-1:DATA_W];
      ALU_SLL: out = a_in << sh;
      ALU_ROR: out = ror_full[DATA_W-1:0];
      ALU_SRL: out = a_in >> sh;
      ALU_OR:  out = a_in | b_in;
      ALU_XOR: out = a_in ^ b_in;
      ALU_AND: out = a_in & b_in;
      default: out = sum;
    endcase
  end

  assign is_add = (op == ALU_ADD);
  assign cout   = is_add & carry;
  assign ofl    = is_add & (sign_op ? sgn_ofl : carry);
  assign neg    = out[DATA_W-1];
  assign zero   = (out == '0);

endmodule

`default_nettype wire

/* execute/branch_unit.sv */
`timescale 1ns/1ns
`default_nettype none

module branch_unit import wisc_pkg::*; (
  input  instr_u instr,
  input  word_t  pc_plus_two,
  input  word_t  op_a,
  input  word_t  imm8,
  input  word_t  imm11,
  input  logic   jump,
  input  logic   branch,
  input  logic   exception,
  input  logic   rti,
  input  word_t  epc,
  input  logic   ofl,
  input  logic   cout,
  input  logic   neg,
  input  logic   zero,
  output logic   cond_bit,
  output word_t  next_pc,
  output logic   flush
);

  logic [1:0] cond_sel;
  logic       lt;
  logic       br_cond;
  logic       jump_reg;
  logic       taken;
  word_t      tgt_base;
  word_t      tgt_offs;
  word_t      target;

  assign cond_sel = instr.r_fmt.opcode[1:0];
  assign lt       = neg ^ ofl;

  always_comb begin
    case (cond_sel)
      2'b00:   cond_bit = zero;
      2'b01:   cond_bit = lt;
      2'b10:   cond_bit = lt | zero;
      default: cond_bit = cout;
    endcase
  end

  // Branches compare rs against zero
  always_comb begin
    case (cond_sel)
      2'b00:   br_cond = zero;
      2'b01:   br_cond = ~zero;
      2'b10:   br_cond = lt;
      default: br_cond = ~lt;
    endcase
  end

  // Register jumps add imm8 to rs
  assign jump_reg = jump & instr.br_fmt.opcode[0];
  assign tgt_base = jump_reg ? op_a : pc_plus_two;
  assign tgt_offs = (jump_reg | branch) ? imm8 : imm11;
  assign target   = tgt_base + tgt_offs;

  assign taken = jump | (branch & br_cond);

  always_comb begin
    if (exception) begin
      next_pc = EXC_VECTOR;
    end else if (rti) begin
      next_pc = epc;
    end else if (taken) begin
      next_pc = target;
    end else begin
      next_pc = pc_plus_two;
    end
  end

  assign flush = exception | rti | taken;

endmodule

`default_nettype wire

/* execute/execute.sv */
`timescale 1ns/1ns
`default_nettype none

module execute import wisc_pkg::*; #(
  parameter int DATA_W = 16
) (
  input  logic      clk,
  input  logic      arst_n,
  input  issue_t    issue,
  input  logic      issue_valid,
  input  word_t     op_a,
  input  word_t     op_b,
  output result_t   result_d,
  output redirect_t redirect_d
);

  word_t             alu_b;
  word_t             alu_out;
  logic              ofl;
  logic              cout;
  logic              neg;
  logic              zero;
  word_t             slbi;
  logic [DATA_W-1:0] btr;
  logic              cond_bit;
  word_t             cond_word;
  word_t             res_word;
  word_t             next_pc;
  logic              flush;
  word_t             epc;

  always_comb begin
    case (issue.b_sel)
      B_IMM5:  alu_b = issue.imm5;
      B_ZERO:  alu_b = '0;
      default: alu_b = op_b;
    endcase
  end

  alu #(
    .DATA_W(DATA_W)
  ) alu_inst (
    .a       (op_a),
    .b       (alu_b),
    .op      (issue.alu_op),
    .cin     (issue.cin),
    .inv_a   (issue.inv_a),
    .inv_b   (issue.inv_b),
    .sign_op (issue.sign_op),
    .out     (alu_out),
    .ofl     (ofl),
    .cout    (cout),
    .neg     (neg),
    .zero    (zero)
  );

  // SLBI keeps the low byte of rs in the upper half
  assign slbi = (op_a << 8) | issue.imm8;

  always_comb begin
    for (int i = 0; i < DATA_W; i++) begin
      btr[i] = op_a[DATA_W-1-i];
    end
  end

  assign cond_word = {{(DATA_W-1){1'b0}}, cond_bit};

  always_comb begin
    case (issue.res_sel)
      RES_SLBI: res_word = slbi;
      RES_BTR:  res_word = btr;
      RES_COND: res_word = cond_word;
      default:  res_word = alu_out;
    endcase
  end

  branch_unit branch_unit_inst (
    .instr       (instr_u'(issue.instr)),
    .pc_plus_two (issue.pc_plus_two),
    .op_a        (op_a),
    .imm8        (issue.imm8),
    .imm11       (issue.imm11),
    .jump        (issue.jump),
    .branch      (issue.branch),
    .exception   (issue.exception),
    .rti         (issue.rti),
    .epc         (epc),
    .ofl         (ofl),
    .cout        (cout),
    .neg         (neg),
    .zero        (zero),
    .cond_bit    (cond_bit),
    .next_pc     (next_pc),
    .flush       (flush)
  );

  // Return address for rti
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      epc <= '0;
    end else if (issue_valid && issue.exception) begin
      epc <= issue.pc_plus_two;
    end
  end

  assign result_d   = '{data: res_word, valid: issue_valid};
  assign redirect_d = '{next_pc: next_pc, flush: flush & issue_valid};

endmodule

`default_nettype wire

/* hdl/operand_fwd.sv */
`timescale 1ns/1ns
`default_nettype none

module operand_fwd import wisc_pkg::*; (
  input  word_t    data1,
  input  word_t    data2,
  input  fwd_sel_e fwd_a,
  input  fwd_sel_e fwd_b,
  input  word_t    wb_data,
  input  word_t    prior_result,
  output word_t    op_a,
  output word_t    op_b
);

  always_comb begin
    case (fwd_a)
      FWD_WB:    op_a = wb_data;
      FWD_PRIOR: op_a = prior_result;
      default:   op_a = data1;
    endcase
  end

  always_comb begin
    case (fwd_b)
      FWD_WB:    op_b = wb_data;
      FWD_PRIOR: op_b = prior_result;
      default:   op_b = data2;
    endcase
  end

endmodule

`default_nettype wire

/* hdl/ex_mem_reg.sv */
`timescale 1ns/1ns
`default_nettype none

module ex_mem_reg import wisc_pkg::*; (
  input  logic      clk,
  input  logic      arst_n,
  input  result_t   result_d,
  input  redirect_t redirect_d,
  output result_t   ex_result,
  output redirect_t ex_redirect,
  output word_t     prior_result
);

  logic  valid_q;
  logic  flush_q;
  word_t result_q;
  word_t next_pc_q;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      valid_q <= 1'b0;
      flush_q <= 1'b0;
    end else begin
      valid_q <= result_d.valid;
      flush_q <= redirect_d.flush;
    end
  end

  // Held across idle cycles for forwarding
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      result_q <= '0;
    end else if (result_d.valid) begin
      result_q <= result_d.data;
    end
  end

  always_ff @(posedge clk) begin
    next_pc_q <= redirect_d.next_pc;
  end

  assign ex_result    = '{data: result_q, valid: valid_q};
  assign ex_redirect  = '{next_pc: next_pc_q, flush: flush_q};
  assign prior_result = result_q;

endmodule

`default_nettype wire

/* hdl/ex_subsystem.sv */
`timescale 1ns/1ns
`default_nettype none

module ex_subsystem import wisc_pkg::*; #(
  parameter int DATA_W = WORD_W
) (
  input  logic      clk,
  input  logic      arst_n,
  input  issue_t    issue,
  input  logic      issue_valid,
  input  word_t     wb_data,
  output result_t   ex_result,
  output redirect_t ex_redirect
);

  word_t     op_a;
  word_t     op_b;
  word_t     prior_result;
  result_t   result_d;
  redirect_t redirect_d;

  operand_fwd operand_fwd_inst (
    .data1        (issue.data1),
    .data2        (issue.data2),
    .fwd_a        (issue.fwd_a),
    .fwd_b        (issue.fwd_b),
    .wb_data      (wb_data),
    .prior_result (prior_result),
    .op_a         (op_a),
    .op_b         (op_b)
  );

  execute #(
    .DATA_W(DATA_W)
  ) execute_inst (
    .clk         (clk),
    .arst_n      (arst_n),
    .issue       (issue),
    .issue_valid (issue_valid),
    .op_a        (op_a),
    .op_b        (op_b),
    .result_d    (result_d),
    .redirect_d  (redirect_d)
  );

  ex_mem_reg ex_mem_reg_inst (
    .clk          (clk),
    .arst_n       (arst_n),
    .result_d     (result_d),
    .redirect_d   (redirect_d),
    .ex_result    (ex_result),
    .ex_redirect  (ex_redirect),
    .prior_result (prior_result)
  );

endmodule

`default_nettype wire

/* verif/tb_ex_subsystem.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_ex_subsystem import wisc_pkg::*; ();

  localparam int N_IDLE   = 10;
  localparam int N_ALU    = 300;
  localparam int N_SHIFT  = 100;
  localparam int N_FWD    = 200;
  localparam int N_BRANCH = 300;
  localparam int N_EXC    = 200;
  localparam int N_RESET  = 8;
  localparam int LIMIT    = 2 * (N_IDLE + N_ALU + N_SHIFT + N_FWD + N_BRANCH + N_EXC) + N_RESET;

  logic      clk = 1'b0;
  logic      arst_n;
  issue_t    issue;
  logic      issue_valid;
  word_t     wb_data;
  result_t   ex_result;
  redirect_t ex_redirect;

  // Model state and the expectation for the next check
  word_t mdl_prior;
  word_t mdl_epc;
  logic  exp_valid;
  logic  exp_flush;
  word_t exp_data;
  word_t exp_next_pc;
  int    errors;
  int    checks;
  int    tests;
  int    failed_tests;
  int    cycle_cnt;

  ex_subsystem #(
    .DATA_W(WORD_W)
  ) ex_subsystem_inst (
    .clk         (clk),
    .arst_n      (arst_n),
    .issue       (issue),
    .issue_valid (issue_valid),
    .wb_data     (wb_data),
    .ex_result   (ex_result),
    .ex_redirect (ex_redirect)
  );

  always #50 clk = ~clk;

  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt >= LIMIT) begin
      $display("Timeout: the run did not finish within %0d cycles", LIMIT);
      $display("** FAIL **");
      $finish;
    end
  end

  task automatic compare(input string what, input word_t got, input word_t exp);
    checks++;
    assert (got === exp) else begin
      $display("** Error @ %0t ns: %s is %h, expected %h", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic alu_model(input word_t a, input word_t b, input alu_op_e op,
                           input logic cin, input logic inv_a, input logic inv_b,
                           input logic sign_op, output word_t out, output logic ofl,
                           output logic cout, output logic neg, output logic zero);
    word_t       ai;
    word_t       bi;
    logic [3:0]  sh;
    logic [16:0] s;
    logic        sofl;
    ai = inv_a ? ~a : a;
    bi = inv_b ? ~b : b;
    sh = bi[3:0];
    s  = {1'b0, ai} + {1'b0, bi} + {16'h0, cin};
    case (op)
      ALU_ROL: out = (ai << sh) | (ai >> (16 - sh));
      ALU_SLL: out = ai << sh;
      ALU_ROR: out = (ai >> sh) | (ai << (16 - sh));
      ALU_SRL: out = ai >> sh;
      ALU_OR:  out = ai | bi;
      ALU_XOR: out = ai ^ bi;
      ALU_AND: out = ai & bi;
      default: out = s[15:0];
    endcase
    sofl = (ai[15] == bi[15]) && (s[15] != ai[15]);
    cout = (op == ALU_ADD) && s[16];
    ofl  = (op == ALU_ADD) && (sign_op ? sofl : s[16]);
    neg  = out[15];
    zero = (out == 16'h0);
  endtask

  function automatic word_t pick_operand(input fwd_sel_e sel, input word_t rf, input word_t wb);
    case (sel)
      FWD_WB:    return wb;
      FWD_PRIOR: return mdl_prior;
      default:   return rf;
    endcase
  endfunction

  task automatic model_step(input issue_t iss, input logic v, input word_t wb);
    word_t a;
    word_t b;
    word_t alu_out;
    word_t res;
    word_t target;
    word_t btr;
    logic  ofl;
    logic  cout;
    logic  neg;
    logic  zero;
    logic  lt;
    logic  setc;
    logic  brc;
    logic  taken;
    logic [1:0] cs;
    a = pick_operand(iss.fwd_a, iss.data1, wb);
    case (iss.b_sel)
      B_IMM5:  b = iss.imm5;
      B_ZERO:  b = 16'h0;
      default: b = pick_operand(iss.fwd_b, iss.data2, wb);
    endcase
    alu_model(a, b, iss.alu_op, iss.cin, iss.inv_a, iss.inv_b, iss.sign_op,
              alu_out, ofl, cout, neg, zero);
    cs   = iss.instr[12:11];
    lt   = neg ^ ofl;
    setc = (cs == 2'd0) ? zero : (cs == 2'd1) ? lt : (cs == 2'd2) ? (lt | zero) : cout;
    brc  = (cs == 2'd0) ? zero : (cs == 2'd1) ? !zero : (cs == 2'd2) ? lt : !lt;
    for (int i = 0; i < 16; i++) begin
      btr[i] = a[15-i];
    end
    case (iss.res_sel)
      RES_SLBI: res = (a << 8) | iss.imm8;
      RES_BTR:  res = btr;
      RES_COND: res = {15'h0, setc};
      default:  res = alu_out;
    endcase
    if (iss.jump && iss.instr[11]) begin
      target = a + iss.imm8;
    end else if (iss.jump) begin
      target = iss.pc_plus_two + iss.imm11;
    end else begin
      target = iss.pc_plus_two + iss.imm8;
    end
    taken = iss.jump | (iss.branch & brc);
    if (iss.exception) begin
      exp_next_pc = EXC_VECTOR;
    end else if (iss.rti) begin
      exp_next_pc = mdl_epc;
    end else if (taken) begin
      exp_next_pc = target;
    end else begin
      exp_next_pc = iss.pc_plus_two;
    end
    exp_valid = v;
    exp_flush = v & (iss.exception | iss.rti | taken);
    exp_data  = res;
    if (v) begin
      mdl_prior = res;
    end
    if (v && iss.exception) begin
      mdl_epc = iss.pc_plus_two;
    end
  endtask

  // Kind 0 is idle, 1 ALU and set, 2 SLBI or BTR, 3 forwarding, 4 branch, 5 exception
  function automatic issue_t rand_issue(input int kind);
    issue_t iss;
    int     r;
    iss             = '0;
    iss.instr       = word_t'($urandom);
    iss.pc          = word_t'($urandom);
    iss.pc_plus_two = iss.pc + 16'd2;
    iss.data1       = word_t'($urandom);
    iss.data2       = word_t'($urandom);
    iss.imm5        = word_t'($urandom);
    iss.imm8        = word_t'($urandom);
    iss.imm11       = word_t'($urandom);
    iss.fwd_a       = FWD_RF;
    iss.fwd_b       = FWD_RF;
    iss.b_sel       = b_sel_e'($urandom_range(0, 2));
    iss.alu_op      = alu_op_e'($urandom_range(0, 7));
    iss.cin         = 1'($urandom);
    iss.inv_a       = 1'($urandom);
    iss.inv_b       = 1'($urandom);
    iss.sign_op     = 1'($urandom);
    iss.res_sel     = RES_ALU;
    r = $urandom_range(0, 3);
    case (kind)
      0: begin
        // Redirect requests that the missing strobe has to mask
        iss.exception = r[0];
        iss.rti       = r[1];
        iss.jump      = (r == 0);
      end
      1: begin
        iss.res_sel = r[0] ? RES_COND : RES_ALU;
        iss.is_set  = r[0];
      end
      2: iss.res_sel = r[0] ? RES_SLBI : RES_BTR;
      3: begin
        iss.fwd_a   = fwd_sel_e'($urandom_range(0, 3));
        iss.fwd_b   = fwd_sel_e'($urandom_range(0, 3));
        iss.res_sel = res_sel_e'(r);
      end
      4: begin
        // Branch compares rs against zero
        iss.b_sel   = B_ZERO;
        iss.alu_op  = ALU_ADD;
        iss.cin     = 1'b0;
        iss.inv_a   = 1'b0;
        iss.inv_b   = 1'b0;
        iss.sign_op = 1'b1;
        if (r == 0) iss.data1 = 16'h0;
        iss.jump    = r[0];
        iss.branch  = !r[0];
      end
      5: begin
        iss.exception = (r == 0) || (r == 2);
        iss.rti       = (r == 1) || (r == 2);
      end
      default: ;
    endcase
    return iss;
  endfunction

  task automatic drive_cycle(input int kind);
    issue_t iss;
    logic   v;
    iss = rand_issue(kind);
    if (kind == 0) v = 1'b0;
    else if (kind == 3) v = 1'b1;
    else v = ($urandom_range(0, 3) != 0);
    issue       = iss;
    issue_valid = v;
    wb_data     = word_t'($urandom);
    model_step(iss, v, wb_data);
  endtask

  task automatic check_outputs();
    compare("ex_result.valid", {15'h0, ex_result.valid}, {15'h0, exp_valid});
    compare("ex_redirect.flush", {15'h0, ex_redirect.flush}, {15'h0, exp_flush});
    if (exp_valid) begin
      compare("ex_result.data", ex_result.data, exp_data);
      compare("ex_redirect.next_pc", ex_redirect.next_pc, exp_next_pc);
    end
  endtask

  task automatic run_test(input string name, input int kind, input int n);
    int err0;
    err0 = errors;
    for (int i = 0; i < n; i++) begin
      @(negedge clk);
      check_outputs();
      drive_cycle(kind);
    end
    @(negedge clk);
    check_outputs();
    drive_cycle(0);
    tests++;
    if (errors != err0) failed_tests++;
    $display("test %-10s %4d cycles, %0d errors", name, n, errors - err0);
  endtask

  initial begin
    void'($urandom(94120));
    arst_n      = 1'b0;
    issue       = '0;
    issue_valid = 1'b0;
    wb_data     = '0;
    mdl_prior   = '0;
    mdl_epc     = '0;
    exp_valid   = 1'b0;
    exp_flush   = 1'b0;
    exp_data    = '0;
    exp_next_pc = '0;
    errors      = 0;
    checks      = 0;
    tests       = 0;
    failed_tests = 0;
    cycle_cnt   = 0;
    repeat (N_RESET) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1;
    run_test("idle", 0, N_IDLE);
    run_test("alu_set", 1, N_ALU);
    run_test("slbi_btr", 2, N_SHIFT);
    run_test("forward", 3, N_FWD);
    run_test("branch", 4, N_BRANCH);
    run_test("exc_rti", 5, N_EXC);
    $display("tests %0d, failed %0d, checks %0d, errors %0d",
             tests, failed_tests, checks, errors);
    if (errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* flist.f */
common/wisc_pkg.sv
execute/alu.sv
execute/branch_unit.sv
execute/execute.sv
hdl/operand_fwd.sv
hdl/ex_mem_reg.sv
hdl/ex_subsystem.sv
verif/tb_ex_subsystem.sv

/* Bender.yml */
package:
  name: ex_subsystem

sources:
  - common/wisc_pkg.sv
  - execute/alu.sv
  - execute/branch_unit.sv
  - execute/execute.sv
  - hdl/operand_fwd.sv
  - hdl/ex_mem_reg.sv
  - hdl/ex_subsystem.sv
  - target: test
    files:
      - verif/tb_ex_subsystem.sv
